// File: verif/pipe_testdata.txt
// op ds a b c dr1 dr2 stall | expected result_a result_b flags ld_gpr1 ld_gpr2 ld_flags
// op and ds use the ex_pkg encodings, every field is hex
0 2 7fffffff 00000001 00000000 1 2 0 80000000 00000000 00000880 1 0 1
0 1 1234ffff 00000001 00000000 2 3 2 00000000 00000000 00000041 1 0 1
0 0 555555f0 abcdef20 00000000 3 4 0 00000010 00000000 00000001 1 0 1
1 2 00000005 00000007 00000000 4 5 0 fffffffe 00000000 00000081 1 0 1
1 0 00000080 00000001 00000000 5 6 1 0000007f 00000000 00000800 1 0 1
2 2 f0f0f0f0 0ff00ff0 00000000 6 7 0 00f000f0 00000000 00000000 1 0 1
3 1 00008000 00000001 00000000 7 0 0 00008001 00000000 00000080 1 0 1
4 2 a5a5a5a5 a5a5a5a5 00000000 0 1 3 00000000 00000000 00000040 1 0 1
5 2 80000001 00000001 00000000 1 2 0 00000002 00000000 00000001 1 0 1
5 0 00000061 00000001 00000000 2 3 0 000000c2 00000000 00000080 1 0 1
6 1 00018005 00000003 00000000 3 4 2 00001000 00000000 00000001 1 0 1
6 2 12345678 00000020 00000000 4 5 0 12345678 00000000 00000001 1 0 1
7 2 00000003 00000003 00000000 5 6 0 00000000 00000000 00000040 0 0 1
8 1 aaaa1111 bbbb2222 00000000 6 7 0 00002222 00001111 00000040 1 1 0
9 2 00001234 0000beef 00001234 7 0 1 0000beef 00000000 00000040 1 0 0
9 0 99887755 00000066 11223344 0 1 0 00000000 00000055 00000040 0 1 0
a 2 00000005 00000006 00000000 1 2 0 ffffffff 00000000 00000040 1 0 0
b 1 dead5678 00000000 00000000 2 3 0 00005678 00000000 00000040 1 0 0
0 2 ffffffff 00000001 00000000 3 4 2 00000000 00000000 00000041 1 0 1
1 1 00007fff 0000ffff 00000000 4 5 0 00008000 00000000 00000881 1 0 1

// File: build.f
design/ex_pkg.sv
design/decode_stage.sv
design/functional_unit_ex.sv
design/result_select_ex.sv
design/execute.sv
design/pipe_top.sv
verif/tb_pipe.sv

// File: verif/tb_pipe.sv
`timescale 1ns/1ps

module tb_pipe;
  import ex_pkg::*;

  localparam int NUM_VEC   = 20;
  localparam int VEC_WORDS = 14;
  // word offsets inside one vector line
  localparam int F_OP    = 0;
  localparam int F_DS    = 1;
  localparam int F_A     = 2;
  localparam int F_B     = 3;
  localparam int F_C     = 4;
  localparam int F_DR1   = 5;
  localparam int F_DR2   = 6;
  localparam int F_STALL = 7;
  localparam int F_RA    = 8;
  localparam int F_RB    = 9;
  localparam int F_FL    = 10;
  localparam int F_L1    = 11;
  localparam int F_L2    = 12;
  localparam int F_LF    = 13;

  logic        CLK = 1'b0;
  logic        rst_n;
  uop_in_t     uop;
  logic        wb_stall;
  wb_latch_t   wb;
  dep_t        dep;
  logic [31:0] flags_out;

  logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];
  int          issue_cyc [0:NUM_VEC-1];
  int          issue_stalls [0:NUM_VEC-1];
  int          line_errs [0:NUM_VEC-1];
  int          exp_q[$];
  int          cyc = 0;
  int          stall_edges = 0;
  int          cur_line = -1;
  int          ex_item = -1;
  int          limit = 0;
  int          errors = 0;
  int          checked = 0;
  int          tests_ok = 0;
  int          max_stall;
  int          nstall;
  int          seed;
  bit          load_ok;

  pipe_top #(.DATA_W(32)) UUT (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .uop       (uop),
    .wb_stall  (wb_stall),
    .wb        (wb),
    .dep       (dep),
    .flags_out (flags_out)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] vec_field(input int idx, input int k);
    return vec_mem[idx*VEC_WORDS + k];
  endfunction

  task automatic report_mismatch(input int idx, input string what,
                                 input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] t=%0d ns test %0d: %s is %h, expected %h", $time, idx, what, got, exp);
    errors++;
    if (idx >= 0) begin
      line_errs[idx]++;
    end
  endtask

  // item sitting in execute must export its own loads
  task automatic check_dep(input int idx);
    logic [2:0] got_ld;
    logic [2:0] exp_ld;
    got_ld = {dep.v_ld_gpr1, dep.v_ld_gpr2, dep.v_ld_flags};
    exp_ld = {vec_field(idx, F_L1) != 0, vec_field(idx, F_L2) != 0, vec_field(idx, F_LF) != 0};
    if (got_ld !== exp_ld) begin
      report_mismatch(idx, "dep load bits", 32'(got_ld), 32'(exp_ld));
    end
    if (32'(dep.dr1) !== vec_field(idx, F_DR1)) begin
      report_mismatch(idx, "dep.dr1", 32'(dep.dr1), vec_field(idx, F_DR1));
    end
    if (32'(dep.dr2) !== vec_field(idx, F_DR2)) begin
      report_mismatch(idx, "dep.dr2", 32'(dep.dr2), vec_field(idx, F_DR2));
    end
  endtask

  task automatic check_wb(input int idx);
    logic [2:0] got_ld;
    logic [2:0] exp_ld;
    got_ld = {wb.ld_gpr1, wb.ld_gpr2, wb.ld_flags};
    exp_ld = {vec_field(idx, F_L1) != 0, vec_field(idx, F_L2) != 0, vec_field(idx, F_LF) != 0};
    if (got_ld !== exp_ld) begin
      report_mismatch(idx, "wb load bits", 32'(got_ld), 32'(exp_ld));
    end
    // results only matter where a register is written
    if (exp_ld[2] && wb.result_a !== vec_field(idx, F_RA)) begin
      report_mismatch(idx, "result_a", wb.result_a, vec_field(idx, F_RA));
    end
    if (exp_ld[1] && wb.result_b !== vec_field(idx, F_RB)) begin
      report_mismatch(idx, "result_b", wb.result_b, vec_field(idx, F_RB));
    end
    if (wb.flags !== vec_field(idx, F_FL)) begin
      report_mismatch(idx, "wb.flags", wb.flags, vec_field(idx, F_FL));
    end
    if (flags_out !== vec_field(idx, F_FL)) begin
      report_mismatch(idx, "flags_out", flags_out, vec_field(idx, F_FL));
    end
    if (32'(wb.dr1) !== vec_field(idx, F_DR1)) begin
      report_mismatch(idx, "wb.dr1", 32'(wb.dr1), vec_field(idx, F_DR1));
    end
    if (32'(wb.dr2) !== vec_field(idx, F_DR2)) begin
      report_mismatch(idx, "wb.dr2", 32'(wb.dr2), vec_field(idx, F_DR2));
    end
    // only meaningful if no stall edge hit the item on its way
    if (stall_edges == issue_stalls[idx] && cyc != issue_cyc[idx] + 2) begin
      report_mismatch(idx, "latency in cycles", 32'(cyc - issue_cyc[idx]), 32'd2);
    end
  endtask

  // cycle count, stall count and which line sits in execute
  always @(posedge CLK) begin
    cyc++;
    if (!rst_n) begin
      ex_item = -1;
    end else if (wb_stall) begin
      stall_edges++;
    end else if (uop.valid) begin
      ex_item = cur_line;
    end else begin
      ex_item = -1;
    end
    if (limit > 0 && cyc == limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // sampled mid-cycle so an item is taken just before an unstalled edge
  always @(negedge CLK) begin
    if (rst_n) begin
      if (ex_item >= 0) begin
        check_dep(ex_item);
      end else if (dep.v_ld_gpr1 || dep.v_ld_gpr2 || dep.v_ld_flags) begin
        report_mismatch(-1, "dep load bits with empty execute",
                        32'({dep.v_ld_gpr1, dep.v_ld_gpr2, dep.v_ld_flags}), 32'd0);
      end
      if (wb.valid && !wb_stall) begin
        if (exp_q.size() == 0) begin
          $display("error: writeback produced an item that was never issued");
          errors++;
        end else begin
          check_wb(exp_q[0]);
          if (line_errs[exp_q[0]] == 0) begin
            $display("test %0d op %0h: ok", exp_q[0], vec_field(exp_q[0], F_OP));
            tests_ok++;
          end else begin
            $display("test %0d op %0h: %0d error(s)", exp_q[0], vec_field(exp_q[0], F_OP),
                     line_errs[exp_q[0]]);
          end
          void'(exp_q.pop_front());
          checked++;
        end
      end
    end
  end

  initial begin
    seed     = $urandom(18509);
    uop      = '0;
    wb_stall = 1'b0;
    rst_n    = 1'b0;
    for (int i = 0; i < NUM_VEC; i++) begin
      line_errs[i] = 0;
    end
    $readmemh("verif/pipe_testdata.txt", vec_mem);
    load_ok = !$isunknown(vec_mem[NUM_VEC*VEC_WORDS-1]);
    if (!load_ok) begin
      $display("error: could not read the test data file verif/pipe_testdata.txt");
      errors++;
    end
    max_stall = 0;
    for (int i = 0; i < NUM_VEC; i++) begin
      if (load_ok && vec_field(i, F_STALL) > max_stall) begin
        max_stall = vec_field(i, F_STALL);
      end
    end
    // one more for the random single-cycle stalls
    max_stall = max_stall + 1;
    limit = NUM_VEC * (2 + max_stall + 2) + 16 + 50;

    repeat (16) @(posedge CLK);
    if (wb.valid !== 1'b0 || flags_out !== 32'h0 ||
        {dep.v_ld_gpr1, dep.v_ld_gpr2, dep.v_ld_flags} !== 3'b000) begin
      report_mismatch(-1, "reset state valid/flags", 32'(wb.valid), 32'd0);
    end else begin
      $display("reset state: ok");
    end
    #2 rst_n = 1'b1;
    @(posedge CLK);
    #2;

    if (load_ok) begin
      for (int i = 0; i < NUM_VEC; i++) begin
        uop.valid    = 1'b1;
        uop.op       = uop_op_e'(4'(vec_field(i, F_OP)));
        uop.datasize = datasize_e'(2'(vec_field(i, F_DS)));
        uop.dr1      = 3'(vec_field(i, F_DR1));
        uop.dr2      = 3'(vec_field(i, F_DR2));
        uop.a        = vec_field(i, F_A);
        uop.b        = vec_field(i, F_B);
        uop.c        = vec_field(i, F_C);
        cur_line     = i;
        nstall = vec_field(i, F_STALL) + (($urandom % 4) == 0 ? 1 : 0);
        repeat (nstall) begin
          wb_stall = 1'b1;
          @(posedge CLK);
          #2;
        end
        wb_stall        = 1'b0;
        issue_cyc[i]    = cyc;
        issue_stalls[i] = stall_edges;
        exp_q.push_back(i);
        @(posedge CLK);
        #2;
      end
      uop.valid = 1'b0;
      wait (checked == NUM_VEC);
      repeat (2) @(posedge CLK);
    end

    if (checked != NUM_VEC) begin
      $display("error: only %0d of %0d issued micro-ops reached writeback", checked, NUM_VEC);
    end
    $display("%0d of %0d tests passed, %0d checked, %0d errors",
             tests_ok, NUM_VEC, checked, errors);
    if (errors == 0 && checked == NUM_VEC) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: design/pipe_top.sv
`timescale 1ns/1ps

module pipe_top #(
  parameter int DATA_W = 32
) (
  input  logic              CLK,
  input  logic              rst_n,
  input  ex_pkg::uop_in_t   uop,
  input  logic              wb_stall,
  output ex_pkg::wb_latch_t wb,
  output ex_pkg::dep_t      dep,
  output logic [31:0]       flags_out
);
  import ex_pkg::*;

  ex_latch_t ex_latch;
  logic      ld_latches;

  // decode latches follow the writeback stall
  decode_stage u_decode_stage (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .uop        (uop),
    .ld_latches (ld_latches),
    .ex_latch   (ex_latch)
  );

  execute #(.DATA_W(DATA_W)) u_execute (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .ex_latch   (ex_latch),
    .wb_stall   (wb_stall),
    .ld_latches (ld_latches),
    .wb         (wb),
    .dep        (dep),
    .flags_out  (flags_out)
  );

endmodule

// File: design/execute.sv
`timescale 1ns/1ps

module execute #(
  parameter int DATA_W = 32
) (
  input  logic              CLK,
  input  logic              rst_n,
  input  ex_pkg::ex_latch_t ex_latch,
  input  logic              wb_stall,
  output logic              ld_latches,
  output ex_pkg::wb_latch_t wb,
  output ex_pkg::dep_t      dep,
  output logic [31:0]       flags_out
);
  import ex_pkg::*;

  logic [31:0]       size_mask;
  logic [31:0]       a_sz;
  logic [31:0]       b_sz;
  logic [31:0]       op_a;
  logic [31:0]       op_b;
  logic [DATA_W-1:0] fu_alu_result;
  logic [DATA_W-1:0] fu_shift_result;
  logic [DATA_W-1:0] fu_count_m1;
  logic [31:0]       alu_flags;
  logic [31:0]       shift_flags;
  logic [31:0]       result_a;
  logic [31:0]       result_b;
  logic [31:0]       new_flags;
  logic              ld_gpr1;
  logic              ld_gpr2;
  logic              v_ld_gpr1;
  logic              v_ld_gpr2;
  logic              v_ld_flags;
  logic              wb_valid_q;
  logic [2:0]        wb_ld_q;
  logic [2:0]        wb_dr1_q;
  logic [2:0]        wb_dr2_q;
  logic [31:0]       wb_result_a_q;
  logic [31:0]       wb_result_b_q;
  logic [31:0]       wb_flags_q;
  logic [31:0]       flags_q;

  always_comb begin
    case (ex_latch.datasize)
      DS_8:    size_mask = 32'h0000_00ff;
      DS_16:   size_mask = 32'h0000_ffff;
      default: size_mask = 32'hffff_ffff;
    endcase
  end

  assign a_sz = ex_latch.a & size_mask;
  assign b_sz = ex_latch.b & size_mask;
  // cmpxchg subtracts the destination from the accumulator in c
  assign op_a = ex_latch.ctrl.is_cmpxchg ? (ex_latch.c & size_mask) : a_sz;
  assign op_b = ex_latch.ctrl.is_cmpxchg ? a_sz : b_sz;

  functional_unit_ex #(.DATA_W(DATA_W)) u_functional_unit_ex (
    .a               (DATA_W'(op_a)),
    .b               (DATA_W'(op_b)),
    .c               (DATA_W'(ex_latch.c)),
    .aluk            (ex_latch.ctrl.aluk),
    .datasize        (ex_latch.datasize),
    .flags_in        (flags_q),
    .alu_result      (fu_alu_result),
    .alu_flags       (alu_flags),
    .shift_result    (fu_shift_result),
    .shift_flags     (shift_flags),
    .count_minus_one (fu_count_m1)
  );

  result_select_ex u_result_select_ex (
    .ctrl            (ex_latch.ctrl),
    .a               (a_sz),
    .b               (b_sz),
    .c               (ex_latch.c),
    .alu_result      (32'(fu_alu_result)),
    .alu_flags       (alu_flags),
    .shift_result    (32'(fu_shift_result)),
    .shift_flags     (shift_flags),
    .count_minus_one (32'(fu_count_m1)),
    .flags_in        (flags_q),
    .result_a        (result_a),
    .result_b        (result_b),
    .flags           (new_flags)
  );

  // cmpxchg: equal writes b to dr1, otherwise the old dest goes to dr2
  assign ld_gpr1 = ex_latch.ctrl.is_cmpxchg ? alu_flags[FLAG_ZF] : ex_latch.ctrl.ld_gpr1;
  assign ld_gpr2 = ex_latch.ctrl.is_cmpxchg ? !alu_flags[FLAG_ZF] : ex_latch.ctrl.ld_gpr2;

  assign v_ld_gpr1  = ex_latch.valid & ld_gpr1;
  assign v_ld_gpr2  = ex_latch.valid & ld_gpr2;
  assign v_ld_flags = ex_latch.valid & ex_latch.ctrl.ld_flags;

  assign dep = '{v_ld_gpr1:  v_ld_gpr1,
                 v_ld_gpr2:  v_ld_gpr2,
                 v_ld_flags: v_ld_flags,
                 dr1:        ex_latch.dr1,
                 dr2:        ex_latch.dr2};

  // one stall freezes decode and writeback latches together
  assign ld_latches = !wb_stall;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
      wb_ld_q    <= 3'b000;
      flags_q    <= 32'h0;
    end else if (!wb_stall) begin
      wb_valid_q <= ex_latch.valid;
      wb_ld_q    <= {v_ld_gpr1, v_ld_gpr2, v_ld_flags};
      if (v_ld_flags) begin
        flags_q <= new_flags;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!wb_stall) begin
      wb_dr1_q      <= ex_latch.dr1;
      wb_dr2_q      <= ex_latch.dr2;
      wb_result_a_q <= result_a;
      wb_result_b_q <= result_b;
      wb_flags_q    <= new_flags;
    end
  end

  assign wb = '{valid:    wb_valid_q,
                ld_gpr1:  wb_ld_q[2],
                ld_gpr2:  wb_ld_q[1],
                ld_flags: wb_ld_q[0],
                dr1:      wb_dr1_q,
                dr2:      wb_dr2_q,
                result_a: wb_result_a_q,
                result_b: wb_result_b_q,
                flags:    wb_flags_q};

  assign flags_out = flags_q;

endmodule

// File: design/result_select_ex.sv
`timescale 1ns/1ps

module result_select_ex (
  input  ex_pkg::ex_ctrl_t ctrl,
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  input  logic [31:0]      c,
  input  logic [31:0]      alu_result,
  input  logic [31:0]      alu_flags,
  input  logic [31:0]      shift_result,
  input  logic [31:0]      shift_flags,
  input  logic [31:0]      count_minus_one,
  input  logic [31:0]      flags_in,
  output logic [31:0]      result_a,
  output logic [31:0]      result_b,
  output logic [31:0]      flags
);

  always_comb begin
    if (ctrl.is_shift) begin
      result_a = shift_result;
    end else if (ctrl.is_xchg || ctrl.is_cmpxchg) begin
      // source goes to the destination register
      result_a = b;
    end else if (ctrl.is_dec_count) begin
      result_a = count_minus_one;
    end else if (ctrl.pass_a) begin
      result_a = a;
    end else begin
      result_a = alu_result;
    end
  end

  // old destination goes back through the second write port
  assign result_b = (ctrl.is_xchg || ctrl.is_cmpxchg) ? a : c;

  always_comb begin
    if (ctrl.is_alu) begin
      flags = alu_flags;
    end else if (ctrl.is_shift) begin
      flags = shift_flags;
    end else begin
      flags = flags_in;
    end
  end

endmodule

// File: design/functional_unit_ex.sv
`timescale 1ns/1ps

module functional_unit_ex #(
  parameter int DATA_W = 32
) (
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] c,
  input  logic [2:0]        aluk,
  input  ex_pkg::datasize_e datasize,
  input  logic [31:0]       flags_in,
  output logic [DATA_W-1:0] alu_result,
  output logic [31:0]       alu_flags,
  output logic [DATA_W-1:0] shift_result,
  output logic [31:0]       shift_flags,
  output logic [DATA_W-1:0] count_minus_one
);
  import ex_pkg::*;

  int                width;
  logic [DATA_W-1:0] mask;
  logic [DATA_W:0]   alu_full;
  logic [DATA_W:0]   shl_full;
  logic [DATA_W:0]   shr_full;
  logic [DATA_W-1:0] shift_raw;
  logic              shift_cf;
  logic [4:0]        shamt;
  logic              sign_a;
  logic              sign_b;
  logic              sign_r;

  // operand width, capped at the datapath
  always_comb begin
    case (datasize)
      DS_8:    width = 8;
      DS_16:   width = 16;
      default: width = 32;
    endcase
    if (width > DATA_W) begin
      width = DATA_W;
    end
  end

  assign mask = {DATA_W{1'b1}} >> (DATA_W - width);

  // operands arrive zero-extended above width, so bit [width] is carry/borrow
  always_comb begin
    case (aluk)
      ALUK_ADD: alu_full = {1'b0, a} + {1'b0, b};
      ALUK_SUB: alu_full = {1'b0, a} - {1'b0, b};
      ALUK_AND: alu_full = {1'b0, a & b};
      ALUK_OR:  alu_full = {1'b0, a | b};
      ALUK_XOR: alu_full = {1'b0, a ^ b};
      default:  alu_full = '0;
    endcase
  end

  assign alu_result = alu_full[DATA_W-1:0] & mask;
  assign sign_a     = a[width-1];
  assign sign_b     = b[width-1];
  assign sign_r     = alu_result[width-1];

  always_comb begin
    alu_flags          = flags_in;
    alu_flags[FLAG_ZF] = (alu_result == '0);
    alu_flags[FLAG_SF] = sign_r;
    // logic ops clear CF and OF
    alu_flags[FLAG_CF] = 1'b0;
    alu_flags[FLAG_OF] = 1'b0;
    if (aluk == ALUK_ADD) begin
      alu_flags[FLAG_CF] = alu_full[width];
      alu_flags[FLAG_OF] = (sign_a == sign_b) && (sign_r != sign_a);
    end else if (aluk == ALUK_SUB) begin
      alu_flags[FLAG_CF] = alu_full[width];
      alu_flags[FLAG_OF] = (sign_a != sign_b) && (sign_r != sign_a);
    end
  end

  assign shamt    = b[4:0];
  assign shl_full = {1'b0, a} << shamt;
  // extra low bit catches the last bit shifted out to the right
  assign shr_full = {a, 1'b0} >> shamt;

  always_comb begin
    if (aluk == ALUK_SHR) begin
      shift_raw = shr_full[DATA_W:1];
      shift_cf  = shr_full[0];
    end else begin
      shift_raw = shl_full[DATA_W-1:0];
      shift_cf  = shl_full[width];
    end
  end

  assign shift_result = shift_raw & mask;

  // OF is left as it was
  always_comb begin
    shift_flags = flags_in;
    if (shamt != 5'd0) begin
      shift_flags[FLAG_CF] = shift_cf;
      shift_flags[FLAG_ZF] = (shift_result == '0);
      shift_flags[FLAG_SF] = shift_result[width-1];
    end
  end

  assign count_minus_one = c - DATA_W'(1);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic              CLK,
  input  logic              rst_n,
  input  ex_pkg::uop_in_t   uop,
  input  logic              ld_latches,
  output ex_pkg::ex_latch_t ex_latch
);
  import ex_pkg::*;

  ex_ctrl_t    ctrl;
  ex_ctrl_t    ctrl_q;
  logic        valid_q;
  datasize_e   datasize_q;
  logic [2:0]  dr1_q;
  logic [2:0]  dr2_q;
  logic [31:0] a_q;
  logic [31:0] b_q;
  logic [31:0] c_q;

  always_comb begin
    ctrl = '0;
    case (uop.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_CMP: ctrl.is_alu = 1'b1;
      OP_SHL, OP_SHR:                                ctrl.is_shift = 1'b1;
      OP_XCHG:                                       ctrl.is_xchg = 1'b1;
      OP_CMPXCHG:                                    ctrl.is_cmpxchg = 1'b1;
      OP_DEC_COUNT:                                  ctrl.is_dec_count = 1'b1;
      OP_PASS:                                       ctrl.pass_a = 1'b1;
      default:                                       ctrl.is_alu = 1'b0;
    endcase

    // compare ops run the subtractor
    case (uop.op)
      OP_SUB, OP_CMP, OP_CMPXCHG: ctrl.aluk = ALUK_SUB;
      OP_AND:                     ctrl.aluk = ALUK_AND;
      OP_OR:                      ctrl.aluk = ALUK_OR;
      OP_XOR:                     ctrl.aluk = ALUK_XOR;
      OP_SHL:                     ctrl.aluk = ALUK_SHL;
      OP_SHR:                     ctrl.aluk = ALUK_SHR;
      default:                    ctrl.aluk = ALUK_ADD;
    endcase

    // cmp only writes flags
    ctrl.ld_gpr1 = (ctrl.is_alu & (uop.op != OP_CMP)) | ctrl.is_shift | ctrl.is_xchg |
                   ctrl.is_cmpxchg | ctrl.is_dec_count | ctrl.pass_a;
    // cmpxchg picks one of the two in execute
    ctrl.ld_gpr2  = ctrl.is_xchg | ctrl.is_cmpxchg;
    ctrl.ld_flags = ctrl.is_alu | ctrl.is_shift;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
    end else if (ld_latches) begin
      valid_q <= uop.valid;
      ctrl_q  <= ctrl;
    end
  end

  always_ff @(posedge CLK) begin
    if (ld_latches) begin
      datasize_q <= uop.datasize;
      dr1_q      <= uop.dr1;
      dr2_q      <= uop.dr2;
      a_q        <= uop.a;
      b_q        <= uop.b;
      c_q        <= uop.c;
    end
  end

  assign ex_latch = '{valid:    valid_q,
                      datasize: datasize_q,
                      ctrl:     ctrl_q,
                      dr1:      dr1_q,
                      dr2:      dr2_q,
                      a:        a_q,
                      b:        b_q,
                      c:        c_q};

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

  // micro-op opcodes, as carried on the uop input
  typedef enum logic [3:0] {
    OP_ADD       = 4'h0,
    OP_SUB       = 4'h1,
    OP_AND       = 4'h2,
    OP_OR        = 4'h3,
    OP_XOR       = 4'h4,
    OP_SHL       = 4'h5,
    OP_SHR       = 4'h6,
    OP_CMP       = 4'h7,
    OP_XCHG      = 4'h8,
    OP_CMPXCHG   = 4'h9,
    OP_DEC_COUNT = 4'ha,
    OP_PASS      = 4'hb
  } uop_op_e;

  typedef enum logic [1:0] {
    DS_8  = 2'd0,
    DS_16 = 2'd1,
    DS_32 = 2'd2
  } datasize_e;

  // function select for the ALU and shifter
  typedef enum logic [2:0] {
    ALUK_ADD = 3'd0,
    ALUK_SUB = 3'd1,
    ALUK_AND = 3'd2,
    ALUK_OR  = 3'd3,
    ALUK_XOR = 3'd4,
    ALUK_SHL = 3'd5,
    ALUK_SHR = 3'd6
  } aluk_e;

  // x86 EFLAGS bit positions
  localparam int FLAG_CF = 0;
  localparam int FLAG_ZF = 6;
  localparam int FLAG_SF = 7;
  localparam int FLAG_OF = 11;

  typedef struct packed {
    logic        valid;
    uop_op_e     op;
    datasize_e   datasize;
    logic [2:0]  dr1;
    logic [2:0]  dr2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } uop_in_t;

  typedef struct packed {
    aluk_e aluk;
    logic  is_alu;
    logic  is_shift;
    logic  is_xchg;
    logic  is_cmpxchg;
    logic  is_dec_count;
    logic  pass_a;
    logic  ld_gpr1;
    logic  ld_gpr2;
    logic  ld_flags;
  } ex_ctrl_t;

  typedef struct packed {
    logic        valid;
    datasize_e   datasize;
    ex_ctrl_t    ctrl;
    logic [2:0]  dr1;
    logic [2:0]  dr2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } ex_latch_t;

  typedef struct packed {
    logic        valid;
    logic        ld_gpr1;
    logic        ld_gpr2;
    logic        ld_flags;
    logic [2:0]  dr1;
    logic [2:0]  dr2;
    logic [31:0] result_a;
    logic [31:0] result_b;
    logic [31:0] flags;
  } wb_latch_t;

  // register and flag writes pending in execute, for the hazard unit
  typedef struct packed {
    logic       v_ld_gpr1;
    logic       v_ld_gpr2;
    logic       v_ld_flags;
    logic [2:0] dr1;
    logic [2:0] dr2;
  } dep_t;

endpackage
